// File: hw/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// data path and address width.
`define CPU_XLEN 32

// number of architectural registers, x0 included.
`define CPU_REGS 32

// memory depths in 32-bit words.
`define CPU_IMEM_WORDS 256
`define CPU_DMEM_WORDS 256

// first fetch address after reset.
`define CPU_RESET_PC 32'h0000_0000

`endif

// File: hw/cpu_pkg.sv
`default_nettype none

`include "cpu_defs.svh"

package cpu_pkg;

    typedef enum logic [6:0] {
        OP_R_TYPE  = 7'b0110011,
        OP_I_ARITH = 7'b0010011,
        OP_LOAD    = 7'b0000011,
        OP_STORE   = 7'b0100011,
        OP_BRANCH  = 7'b1100011
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5
    } alu_op_t;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    branch;
        logic    alu_src; // second alu input is the immediate.
        alu_op_t alu_op;
    } control_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_t;

    typedef struct packed {
        logic [`CPU_XLEN-1:0] pc;
        instr_t               instr;
    } if_id_t;

    typedef struct packed {
        logic [`CPU_XLEN-1:0] pc;
        logic [4:0]           rs1;
        logic [4:0]           rs2;
        logic [4:0]           rd;
        logic [`CPU_XLEN-1:0] data1;
        logic [`CPU_XLEN-1:0] data2;
        logic [`CPU_XLEN-1:0] immediate;
        control_t             control;
    } id_ex_t;

    typedef struct packed {
        logic [4:0]           rd;
        logic [`CPU_XLEN-1:0] alu_data;
        logic [`CPU_XLEN-1:0] store_data;
        control_t             control;
    } ex_mem_t;

    typedef struct packed {
        logic [4:0]           rd;
        logic [`CPU_XLEN-1:0] alu_data;
        logic [`CPU_XLEN-1:0] memory_data;
        control_t             control;
    } mem_wb_t;

    typedef enum logic [1:0] {
        FWD_REG = 2'b00,
        FWD_WB  = 2'b01,
        FWD_MEM = 2'b10
    } fwd_sel_t;

    typedef struct packed {
        logic                                  we;
        logic [$clog2(`CPU_IMEM_WORDS)-1:0] addr; // word index, not byte address.
        logic [`CPU_XLEN-1:0]                  data;
    } prog_write_t;

    typedef struct packed {
        logic                 valid;
        logic [4:0]           rd;
        logic [`CPU_XLEN-1:0] data;
    } retire_t;

endpackage

`default_nettype wire

// File: hw/program_memory.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module program_memory import cpu_pkg::*; (
    input  logic                                  clk,
    input  prog_write_t                           prog,
    input  logic [$clog2(`CPU_IMEM_WORDS)-1:0] word_address,
    output instr_t                                instruction
);

    logic [`CPU_XLEN-1:0] mem [`CPU_IMEM_WORDS];

    // the load port writes one word per clock while we is high.
    always_ff @(posedge clk) begin
        if (prog.we) begin
            mem[prog.addr] <= prog.data;
        end
    end

    assign instruction = mem[word_address]; // fetch sees the latest loaded word.

endmodule

`default_nettype wire

// File: hw/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module decode_stage import cpu_pkg::*; (
    input  logic                 clk,
    input  logic                 reset_n,
    input  if_id_t               if_id,
    input  logic                 write_en,
    input  logic [4:0]           write_id,
    input  logic [`CPU_XLEN-1:0] write_data,
    output logic [4:0]           rd,
    output logic [`CPU_XLEN-1:0] data1,
    output logic [`CPU_XLEN-1:0] data2,
    output logic [`CPU_XLEN-1:0] immediate,
    output control_t             control
);

    logic [`CPU_XLEN-1:0] regs [`CPU_REGS];
    instr_t               instr;
    logic [31:0]          raw;

    assign instr = if_id.instr;
    assign raw   = if_id.instr;
    assign rd    = instr.rd;

    always_ff @(posedge clk) begin
        if (write_en && write_id != 5'd0) begin
            regs[write_id] <= write_data;
        end
    end

    // write-back in the same cycle is passed straight through.
    always_comb begin
        if (instr.rs1 == 5'd0) data1 = '0;
        else if (write_en && write_id == instr.rs1) data1 = write_data;
        else data1 = regs[instr.rs1];
        if (instr.rs2 == 5'd0) data2 = '0;
        else if (write_en && write_id == instr.rs2) data2 = write_data;
        else data2 = regs[instr.rs2];
    end

    always_comb begin
        control   = '0; // unsupported encodings fall through as no-ops.
        immediate = {{20{raw[31]}}, raw[31:20]};
        case (instr.opcode)
            OP_R_TYPE: begin
                control.reg_write = (instr.funct7 == 7'b0000000) ||
                                    (instr.funct7 == 7'b0100000 && instr.funct3 == 3'b000);
                case (instr.funct3)
                    3'b000: control.alu_op = instr.funct7[5] ? ALU_SUB : ALU_ADD;
                    3'b111: control.alu_op = ALU_AND;
                    3'b110: control.alu_op = ALU_OR;
                    3'b100: control.alu_op = ALU_XOR;
                    3'b010: control.alu_op = ALU_SLT;
                    default: control.reg_write = 1'b0;
                endcase
            end
            OP_I_ARITH: begin
                control.reg_write = (instr.funct3 == 3'b000);
                control.alu_src   = 1'b1;
            end
            OP_LOAD: begin
                control.reg_write = (instr.funct3 == 3'b010);
                control.mem_read  = (instr.funct3 == 3'b010);
                control.alu_src   = 1'b1;
            end
            OP_STORE: begin
                control.mem_write = (instr.funct3 == 3'b010);
                control.alu_src   = 1'b1;
                immediate = {{20{raw[31]}}, raw[31:25], raw[11:7]};
            end
            OP_BRANCH: begin
                control.branch = (instr.funct3 == 3'b000);
                control.alu_op = ALU_SUB;
                immediate = {{19{raw[31]}}, raw[31], raw[7], raw[30:25], raw[11:8], 1'b0};
            end
            default: ;
        endcase
    end

    // a written register reads back its new value in the next cycle.
    assert property (@(posedge clk) disable iff (!reset_n)
        write_en && write_id != 5'd0 |=>
            instr.rs1 != $past(write_id) || (write_en && write_id == instr.rs1) ||
            data1 == $past(write_data))
        else $error("register file did not return the written value");

endmodule

`default_nettype wire

// File: hw/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module execute_stage import cpu_pkg::*; (
    input  id_ex_t               id_ex,
    input  fwd_sel_t             fwd_a,
    input  fwd_sel_t             fwd_b,
    input  logic [`CPU_XLEN-1:0] mem_forward_data,
    input  logic [`CPU_XLEN-1:0] wb_forward_data,
    output logic [`CPU_XLEN-1:0] alu_data,
    output logic [`CPU_XLEN-1:0] store_data,
    output control_t             control_out,
    output logic                 branch_taken,
    output logic [`CPU_XLEN-1:0] branch_target
);

    logic [`CPU_XLEN-1:0] operand_a;
    logic [`CPU_XLEN-1:0] operand_b_reg;
    logic [`CPU_XLEN-1:0] operand_b;

    always_comb begin
        case (fwd_a)
            FWD_MEM: operand_a = mem_forward_data;
            FWD_WB:  operand_a = wb_forward_data;
            default: operand_a = id_ex.data1;
        endcase
        case (fwd_b)
            FWD_MEM: operand_b_reg = mem_forward_data;
            FWD_WB:  operand_b_reg = wb_forward_data;
            default: operand_b_reg = id_ex.data2;
        endcase
    end

    assign operand_b  = id_ex.control.alu_src ? id_ex.immediate : operand_b_reg;
    assign store_data = operand_b_reg; // store data needs forwarding too.

    always_comb begin
        case (id_ex.control.alu_op)
            ALU_SUB: alu_data = operand_a - operand_b;
            ALU_AND: alu_data = operand_a & operand_b;
            ALU_OR:  alu_data = operand_a | operand_b;
            ALU_XOR: alu_data = operand_a ^ operand_b;
            ALU_SLT: alu_data = {31'd0, $signed(operand_a) < $signed(operand_b)};
            default: alu_data = operand_a + operand_b;
        endcase
    end

    assign control_out   = id_ex.control;
    assign branch_taken  = id_ex.control.branch && (operand_a == operand_b_reg);
    assign branch_target = id_ex.pc + id_ex.immediate;

    // the hazard unit only ever picks one of the three sources.
    always_comb begin
        assert (fwd_a != 2'b11 && fwd_b != 2'b11)
            else $error("forwarding select uses the unused encoding");
    end

endmodule

`default_nettype wire

// File: hw/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module mem_stage import cpu_pkg::*; (
    input  logic                 clk,
    input  ex_mem_t              ex_mem,
    output logic [`CPU_XLEN-1:0] memory_data
);

    localparam int ADDR_BITS = $clog2(`CPU_DMEM_WORDS);

    logic [`CPU_XLEN-1:0] mem [`CPU_DMEM_WORDS];
    logic [ADDR_BITS-1:0] word_address;

    assign word_address = ex_mem.alu_data[ADDR_BITS+1:2]; // byte address to word index.

    always_ff @(posedge clk) begin
        if (ex_mem.control.mem_write) begin
            mem[word_address] <= ex_mem.store_data;
        end
    end

    assign memory_data = ex_mem.control.mem_read ? mem[word_address] : '0;

    // only whole-word accesses exist, so addresses must be word aligned.
    assert property (@(posedge clk)
        ex_mem.control.mem_read || ex_mem.control.mem_write |-> ex_mem.alu_data[1:0] == 2'b00)
        else $error("misaligned data memory access at %h", ex_mem.alu_data);

endmodule

`default_nettype wire

// File: hw/hazard_control.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_control import cpu_pkg::*; (
    input  logic [4:0] if_id_rs1,
    input  logic [4:0] if_id_rs2,
    input  id_ex_t     id_ex,
    input  logic [4:0] ex_mem_rd,
    input  logic [4:0] mem_wb_rd,
    input  logic       ex_mem_reg_write,
    input  logic       mem_wb_reg_write,
    input  logic       branch_taken,
    output fwd_sel_t   fwd_a,
    output fwd_sel_t   fwd_b,
    output logic       stall,
    output logic       flush_if_id,
    output logic       flush_id_ex
);

    logic mem_hit_a;
    logic mem_hit_b;
    logic wb_hit_a;
    logic wb_hit_b;
    logic load_use;

    assign mem_hit_a = ex_mem_reg_write && ex_mem_rd != 5'd0 && ex_mem_rd == id_ex.rs1;
    assign mem_hit_b = ex_mem_reg_write && ex_mem_rd != 5'd0 && ex_mem_rd == id_ex.rs2;
    assign wb_hit_a  = mem_wb_reg_write && mem_wb_rd != 5'd0 && mem_wb_rd == id_ex.rs1;
    assign wb_hit_b  = mem_wb_reg_write && mem_wb_rd != 5'd0 && mem_wb_rd == id_ex.rs2;

    // the younger result in EX/MEM wins over MEM/WB.
    assign fwd_a = mem_hit_a ? FWD_MEM : (wb_hit_a ? FWD_WB : FWD_REG);
    assign fwd_b = mem_hit_b ? FWD_MEM : (wb_hit_b ? FWD_WB : FWD_REG);

    assign load_use = id_ex.control.mem_read && id_ex.rd != 5'd0 &&
                      (id_ex.rd == if_id_rs1 || id_ex.rd == if_id_rs2);

    // a taken branch discards the dependent instruction anyway.
    assign stall       = load_use && !branch_taken;
    assign flush_if_id = branch_taken;
    assign flush_id_ex = branch_taken;

    // the instruction in execute is a load or a branch, never both.
    always_comb begin
        assert (!(load_use && branch_taken))
            else $error("load-use stall and taken branch requested in the same cycle");
    end

endmodule

`default_nettype wire

// File: hw/cpu.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module cpu import cpu_pkg::*; (
    input  logic        clk,
    input  logic        reset_n,
    input  prog_write_t prog,
    output retire_t     retire
);

    logic [`CPU_XLEN-1:0] pc;
    instr_t               fetch_instr;
    if_id_t               if_id;
    id_ex_t               id_ex;
    ex_mem_t              ex_mem;
    mem_wb_t              mem_wb;

    logic [4:0]           dec_rd;
    logic [`CPU_XLEN-1:0] dec_data1;
    logic [`CPU_XLEN-1:0] dec_data2;
    logic [`CPU_XLEN-1:0] dec_immediate;
    control_t             dec_control;

    fwd_sel_t             fwd_a;
    fwd_sel_t             fwd_b;
    logic [`CPU_XLEN-1:0] ex_alu_data;
    logic [`CPU_XLEN-1:0] ex_store_data;
    control_t             ex_control;
    logic                 branch_taken;
    logic [`CPU_XLEN-1:0] branch_target;
    logic [`CPU_XLEN-1:0] mem_data;
    logic                 stall;
    logic                 flush_if_id;
    logic                 flush_id_ex;
    logic [`CPU_XLEN-1:0] wb_result;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            pc     <= `CPU_RESET_PC;
            if_id  <= '0;
            id_ex  <= '0;
            ex_mem <= '0;
            mem_wb <= '0;
        end else begin
            if (branch_taken) pc <= branch_target;
            else if (!stall) pc <= pc + 32'd4;

            if (flush_if_id) if_id <= '0;
            else if (!stall) if_id <= '{pc: pc, instr: fetch_instr};

            if (flush_id_ex || stall) begin
                id_ex <= '0; // bubble into execute.
            end else begin
                id_ex <= '{pc: if_id.pc, rs1: if_id.instr.rs1, rs2: if_id.instr.rs2,
                           rd: dec_rd, data1: dec_data1, data2: dec_data2,
                           immediate: dec_immediate, control: dec_control};
            end

            ex_mem <= '{rd: id_ex.rd, alu_data: ex_alu_data, store_data: ex_store_data,
                        control: ex_control};
            mem_wb <= '{rd: ex_mem.rd, alu_data: ex_mem.alu_data, memory_data: mem_data,
                        control: ex_mem.control};
        end
    end

    program_memory u_program_memory (
        .clk          (clk),
        .prog         (prog),
        .word_address (pc[$clog2(`CPU_IMEM_WORDS)+1:2]),
        .instruction  (fetch_instr)
    );

    decode_stage u_decode_stage (
        .clk        (clk),
        .reset_n    (reset_n),
        .if_id      (if_id),
        .write_en   (mem_wb.control.reg_write),
        .write_id   (mem_wb.rd),
        .write_data (wb_result),
        .rd         (dec_rd),
        .data1      (dec_data1),
        .data2      (dec_data2),
        .immediate  (dec_immediate),
        .control    (dec_control)
    );

    execute_stage u_execute_stage (
        .id_ex            (id_ex),
        .fwd_a            (fwd_a),
        .fwd_b            (fwd_b),
        .mem_forward_data (ex_mem.alu_data),
        .wb_forward_data  (wb_result),
        .alu_data         (ex_alu_data),
        .store_data       (ex_store_data),
        .control_out      (ex_control),
        .branch_taken     (branch_taken),
        .branch_target    (branch_target)
    );

    mem_stage u_mem_stage (
        .clk         (clk),
        .ex_mem      (ex_mem),
        .memory_data (mem_data)
    );

    hazard_control u_hazard_control (
        .if_id_rs1        (if_id.instr.rs1),
        .if_id_rs2        (if_id.instr.rs2),
        .id_ex            (id_ex),
        .ex_mem_rd        (ex_mem.rd),
        .mem_wb_rd        (mem_wb.rd),
        .ex_mem_reg_write (ex_mem.control.reg_write),
        .mem_wb_reg_write (mem_wb.control.reg_write),
        .branch_taken     (branch_taken),
        .fwd_a            (fwd_a),
        .fwd_b            (fwd_b),
        .stall            (stall),
        .flush_if_id      (flush_if_id),
        .flush_id_ex      (flush_id_ex)
    );

    assign wb_result = mem_wb.control.mem_read ? mem_wb.memory_data : mem_wb.alu_data;

    // writes to x0 are dropped, so they never show up as retired.
    assign retire.valid = mem_wb.control.reg_write && mem_wb.rd != 5'd0;
    assign retire.rd    = mem_wb.rd;
    assign retire.data  = wb_result;

endmodule

`default_nettype wire

// File: dv/cpu_checker.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_checker import cpu_pkg::*; #(
    parameter int MAX_EVENTS = 64
) (
    input  logic        clk,
    input  logic        reset_n,
    input  retire_t     retire,
    input  logic [4:0]  expected_rd [MAX_EVENTS],
    input  logic [31:0] expected_data [MAX_EVENTS],
    input  int          expected_count,
    input  logic        end_of_test,
    output logic        all_retired,
    output int          mismatch_count,
    output int          extra_count,
    output int          missing_count
);

    int   retired_count;
    logic end_reported;

    assign all_retired   = (expected_count > 0) && (retired_count >= expected_count);
    assign missing_count = (retired_count < expected_count) ? expected_count - retired_count : 0;

    // retire comes straight from MEM/WB, so the value before the edge is the settled one.
    always @(posedge clk) begin : compare
        logic wrong;
        if (!reset_n) begin
            retired_count  <= 0;
            mismatch_count <= 0;
            extra_count    <= 0;
        end else if (retire.valid) begin
            wrong = 1'b0;
            if (retired_count >= expected_count) begin
                $display("unexpected write-back to x%0d with value %h after the last expected one",
                         retire.rd, retire.data);
                extra_count <= extra_count + 1;
            end else begin
                if (retire.rd !== expected_rd[retired_count]) begin
                    $display("[ERROR] retire.rd: got %h, expected %h at write-back %0d",
                             retire.rd, expected_rd[retired_count], retired_count);
                    wrong = 1'b1;
                end
                if (retire.data !== expected_data[retired_count]) begin
                    $display("[ERROR] retire.data: got %h, expected %h at write-back %0d",
                             retire.data, expected_data[retired_count], retired_count);
                    wrong = 1'b1;
                end
                if (wrong) mismatch_count <= mismatch_count + 1; // one error per write-back.
            end
            retired_count <= retired_count + 1;
        end
    end

    always @(posedge clk) begin
        if (!reset_n) begin
            end_reported <= 1'b0;
        end else if (end_of_test && !end_reported) begin
            end_reported <= 1'b1;
            if (missing_count != 0) begin
                $display("%0d expected write-backs never retired, the first missing one is x%0d",
                         missing_count, expected_rd[retired_count]);
            end
        end
    end

endmodule

`default_nettype wire

// File: dv/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_tb import cpu_pkg::*; ();

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 5;
    localparam int DRAIN_CYCLES = 10;
    localparam int MAX_EVENTS   = 64;

    typedef struct packed {
        logic [31:0] instr;
        logic        writes;
        logic [4:0]  rd;
        logic [31:0] value;
    } row_t;

    logic        clk;
    logic        reset_n;
    prog_write_t prog;
    retire_t     retire;
    logic        end_of_test;
    logic        timed_out;
    logic        all_retired;
    int          mismatch_count;
    int          extra_count;
    int          missing_count;
    row_t        program_table [$];
    logic [4:0]  expected_rd [MAX_EVENTS];
    logic [31:0] expected_data [MAX_EVENTS];
    int          expected_count;
    bit          table_ready;

    always #(CLK_PERIOD / 2) clk = ~clk;

    cpu DUT (
        .clk     (clk),
        .reset_n (reset_n),
        .prog    (prog),
        .retire  (retire)
    );

    cpu_checker #(.MAX_EVENTS(MAX_EVENTS)) u_cpu_checker (
        .clk            (clk),
        .reset_n        (reset_n),
        .retire         (retire),
        .expected_rd    (expected_rd),
        .expected_data  (expected_data),
        .expected_count (expected_count),
        .end_of_test    (end_of_test || timed_out),
        .all_retired    (all_retired),
        .mismatch_count (mismatch_count),
        .extra_count    (extra_count),
        .missing_count  (missing_count)
    );

    function automatic logic [31:0] encode_r(input logic [6:0] funct7, input logic [2:0] funct3,
                                             input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
        return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] encode_addi(input logic [11:0] imm, input logic [4:0] rd,
                                                input logic [4:0] rs1);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] encode_lw(input logic [11:0] imm, input logic [4:0] rd,
                                              input logic [4:0] rs1);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] encode_sw(input logic [11:0] imm, input logic [4:0] rs2,
                                              input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] encode_beq(input logic [12:0] offset, input logic [4:0] rs1,
                                               input logic [4:0] rs2);
        return {offset[12], offset[10:5], rs2, rs1, 3'b000, offset[4:1], offset[11], 7'b1100011};
    endfunction

    task automatic add_row(input logic [31:0] instr, input logic writes, input logic [4:0] rd,
                           input logic [31:0] value);
        program_table.push_back('{instr: instr, writes: writes, rd: rd, value: value});
    endtask

    task automatic build_program();
        add_row(encode_addi(12'd5, 5'd1, 5'd0), 1'b1, 5'd1, 32'h5);
        add_row(encode_addi(12'hffd, 5'd2, 5'd0), 1'b1, 5'd2, 32'hffff_fffd); // x2 = -3.
        add_row(encode_addi(12'd12, 5'd3, 5'd0), 1'b1, 5'd3, 32'hc);
        add_row(encode_addi(12'd10, 5'd4, 5'd0), 1'b1, 5'd4, 32'ha);
        add_row(encode_r(7'h00, 3'b000, 5'd5, 5'd1, 5'd3), 1'b1, 5'd5, 32'h11); // add.
        add_row(encode_r(7'h20, 3'b000, 5'd6, 5'd1, 5'd3), 1'b1, 5'd6, 32'hffff_fff9); // sub.
        add_row(encode_r(7'h00, 3'b111, 5'd7, 5'd3, 5'd4), 1'b1, 5'd7, 32'h8); // and.
        add_row(encode_r(7'h00, 3'b110, 5'd8, 5'd3, 5'd4), 1'b1, 5'd8, 32'he); // or.
        add_row(encode_r(7'h00, 3'b100, 5'd9, 5'd3, 5'd4), 1'b1, 5'd9, 32'h6); // xor.
        add_row(encode_r(7'h00, 3'b010, 5'd10, 5'd2, 5'd1), 1'b1, 5'd10, 32'h1); // -3 < 5.
        add_row(encode_r(7'h00, 3'b010, 5'd11, 5'd1, 5'd2), 1'b1, 5'd11, 32'h0);
        // in this dependent chain x15 reads x12 through the register file.
        add_row(encode_addi(12'd1, 5'd12, 5'd0), 1'b1, 5'd12, 32'h1);
        add_row(encode_r(7'h00, 3'b000, 5'd13, 5'd12, 5'd12), 1'b1, 5'd13, 32'h2);
        add_row(encode_r(7'h00, 3'b000, 5'd14, 5'd13, 5'd12), 1'b1, 5'd14, 32'h3);
        add_row(encode_r(7'h00, 3'b000, 5'd15, 5'd12, 5'd14), 1'b1, 5'd15, 32'h4);
        add_row(encode_r(7'h20, 3'b000, 5'd16, 5'd15, 5'd13), 1'b1, 5'd16, 32'h2);
        add_row(encode_addi(12'd64, 5'd17, 5'd0), 1'b1, 5'd17, 32'h40); // data base address.
        add_row(encode_sw(12'd8, 5'd15, 5'd17), 1'b0, 5'd0, 32'h0);
        add_row(encode_lw(12'd8, 5'd18, 5'd17), 1'b1, 5'd18, 32'h4);
        add_row(encode_r(7'h00, 3'b000, 5'd19, 5'd18, 5'd1), 1'b1, 5'd19, 32'h9); // load use.
        add_row(encode_sw(12'd0, 5'd16, 5'd17), 1'b0, 5'd0, 32'h0);
        add_row(encode_lw(12'd0, 5'd20, 5'd17), 1'b1, 5'd20, 32'h2);
        add_row(encode_addi(12'd100, 5'd21, 5'd20), 1'b1, 5'd21, 32'h66); // load use.
        add_row(encode_addi(12'h123, 5'd22, 5'd0), 1'b1, 5'd22, 32'h123);
        add_row(encode_sw(12'd4, 5'd22, 5'd17), 1'b0, 5'd0, 32'h0); // forwarded store data.
        add_row(encode_lw(12'd4, 5'd23, 5'd17), 1'b1, 5'd23, 32'h123);
        add_row(encode_beq(13'd12, 5'd1, 5'd5), 1'b0, 5'd0, 32'h0); // 5 != 17 so it falls through.
        add_row(encode_addi(12'd7, 5'd24, 5'd0), 1'b1, 5'd24, 32'h7);
        add_row(encode_addi(12'd8, 5'd25, 5'd0), 1'b1, 5'd25, 32'h8);
        add_row(encode_beq(13'd12, 5'd13, 5'd16), 1'b0, 5'd0, 32'h0); // 2 == 2 so it is taken.
        add_row(encode_addi(12'h55, 5'd26, 5'd0), 1'b0, 5'd0, 32'h0);
        add_row(encode_addi(12'h66, 5'd27, 5'd0), 1'b0, 5'd0, 32'h0);
        add_row(encode_addi(12'd1, 5'd28, 5'd25), 1'b1, 5'd28, 32'h9);
        add_row(encode_addi(12'd9, 5'd29, 5'd0), 1'b1, 5'd29, 32'h9);
        add_row(encode_beq(13'd12, 5'd29, 5'd28), 1'b0, 5'd0, 32'h0); // both operands forwarded.
        add_row(encode_addi(12'd1, 5'd30, 5'd0), 1'b0, 5'd0, 32'h0);
        add_row(encode_addi(12'd1, 5'd31, 5'd0), 1'b0, 5'd0, 32'h0);
        add_row(encode_addi(12'd77, 5'd0, 5'd0), 1'b0, 5'd0, 32'h0);
        add_row(encode_r(7'h00, 3'b000, 5'd0, 5'd1, 5'd3), 1'b0, 5'd0, 32'h0);
        add_row(encode_r(7'h00, 3'b000, 5'd26, 5'd0, 5'd1), 1'b1, 5'd26, 32'h5);
        add_row(encode_r(7'h20, 3'b000, 5'd27, 5'd0, 5'd1), 1'b1, 5'd27, 32'hffff_fffb);
        add_row(encode_beq(13'd0, 5'd0, 5'd0), 1'b0, 5'd0, 32'h0); // self loop.
        add_row(encode_addi(12'd0, 5'd0, 5'd0), 1'b0, 5'd0, 32'h0);
        add_row(encode_addi(12'd0, 5'd0, 5'd0), 1'b0, 5'd0, 32'h0);
    endtask

    task automatic collect_expected();
        expected_count = 0;
        for (int i = 0; i < MAX_EVENTS; i++) begin
            expected_rd[i]   = '0;
            expected_data[i] = '0;
        end
        foreach (program_table[i]) begin
            if (program_table[i].writes) begin
                expected_rd[expected_count]   = program_table[i].rd;
                expected_data[expected_count] = program_table[i].value;
                expected_count++;
            end
        end
    endtask

    initial begin : main
        int total_errors;
        clk         = 1'b0;
        reset_n     = 1'b0;
        prog        = '0;
        end_of_test = 1'b0;
        timed_out   = 1'b0;
        build_program();
        collect_expected();
        table_ready = 1'b1;
        foreach (program_table[i]) begin
            @(posedge clk);
            prog.we   <= 1'b1;
            prog.addr <= 8'(i);
            prog.data <= program_table[i].instr;
        end
        @(posedge clk);
        prog <= '0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset_n <= 1'b1;
        while (!all_retired) @(posedge clk);
        repeat (DRAIN_CYCLES) @(posedge clk); // lets any stray write-back show up.
        end_of_test <= 1'b1;
        repeat (2) @(posedge clk);
        total_errors = mismatch_count + extra_count + missing_count;
        $display("errors: %0d mismatched, %0d unexpected, %0d missing",
                 mismatch_count, extra_count, missing_count);
        if (total_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin : watchdog
        int limit;
        wait (table_ready);
        limit = 20 * program_table.size() + 100;
        repeat (limit) @(posedge clk);
        timed_out <= 1'b1; // the checker names the first missing write-back.
        repeat (2) @(posedge clk);
        $display("timeout after %0d cycles, only %0d of %0d expected write-backs retired",
                 limit, expected_count - missing_count, expected_count);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+hw
hw/cpu_pkg.sv
hw/program_memory.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/mem_stage.sv
hw/hazard_control.sv
hw/cpu.sv
dv/cpu_checker.sv
dv/cpu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= cpu_tb
FILE_LIST ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Done: no errors
VFLAGS    ?= --binary --assert -Wno-fatal -j 0

SOURCES := $(shell grep -v '^+' $(FILE_LIST)) $(wildcard hw/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG) && echo "simulation passed" || (echo "simulation failed"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
